//--- hdl/counterPkg.sv
// counter CSR package
// shared widths, CSR addresses, privilege codes and the structs
// that travel between the counter blocks
`default_nettype none

package counterPkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int XLEN         = 64;
    localparam int NUM_COUNTERS = 8;
    localparam int CSR_ADDR_W   = 12;
    // low address bits select the counter slot
    localparam int INDEX_W      = $clog2(NUM_COUNTERS);

    //////////////////////////////////////////////////
    // CSR addresses
    //////////////////////////////////////////////////
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTER_BASE = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_UCOUNTER_BASE = 12'hC00;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTINHIBIT = 12'h320;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTEREN    = 12'h306;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SCOUNTEREN    = 12'h106;

    // time slot, not implemented here
    localparam int TIME_INDEX = 1;

    // privilege encodings as in mstatus.MPP
    typedef enum logic [1:0] {
        U = 2'b00,
        S = 2'b01,
        M = 2'b11
    } privMode_t;

    // raw event levels from the pipeline
    typedef struct packed {
        logic instrValid;
        logic loadStall;
        logic predWrong;
        logic instrClass0;
    } counterEvents_t;

    // CSR request from the core
    typedef struct packed {
        logic [CSR_ADDR_W-1:0] addr;
        logic                  write;
        logic [XLEN-1:0]       wdata;
        privMode_t             priv;
    } csrReq_t;

    // mcountinhibit / mcounteren / scounteren
    typedef struct packed {
        logic [NUM_COUNTERS-1:0] inhibit;
        logic [NUM_COUNTERS-1:0] mEnable;
        logic [NUM_COUNTERS-1:0] sEnable;
    } counterEnables_t;

    // result of the read decode
    typedef struct packed {
        logic               legal;
        logic               isCounter;
        logic [INDEX_W-1:0] index;
    } accessDecision_t;

    typedef logic [NUM_COUNTERS-1:0][XLEN-1:0] counterValues_t;

endpackage

`default_nettype wire

//--- hdl/counterCtrlRegs.sv
// counter enable registers
// holds mcountinhibit, mcounteren and scounteren and decodes their writes
`default_nettype none

module counterCtrlRegs import counterPkg::*; (
    input  wire logic      clk,
    input  wire logic      arstN,
    input  csrReq_t        csrReq,
    output counterEnables_t enables
);

    logic                    inhibitWr;
    logic                    mEnableWr;
    logic                    sEnableWr;
    logic [NUM_COUNTERS-1:0] wrVal;

    //////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////
    always_comb begin
        // write legality already checked by the core
        inhibitWr = csrReq.write && (csrReq.addr == ADDR_MCOUNTINHIBIT);
        mEnableWr = csrReq.write && (csrReq.addr == ADDR_MCOUNTEREN);
        sEnableWr = csrReq.write && (csrReq.addr == ADDR_SCOUNTEREN);
        // only the low bits map onto real slots
        wrVal = csrReq.wdata[NUM_COUNTERS-1:0];
        // time slot bit is hardwired to zero
        wrVal[TIME_INDEX] = 1'b0;
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enables <= '0;
        end else begin
            // bit 0 stays writable so the cycle counter can stop
            if (inhibitWr) begin
                enables.inhibit <= wrVal;
            end
            if (mEnableWr) begin
                enables.mEnable <= wrVal;
            end
            if (sEnableWr) begin
                enables.sEnable <= wrVal;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/counterBank.sv
// counter bank
// eight 64-bit counters with event increment, inhibit and
// machine-mode writes; the time slot stays at zero
`default_nettype none

module counterBank import counterPkg::*; (
    input  wire logic       clk,
    input  wire logic       arstN,
    input  csrReq_t         csrReq,
    input  counterEvents_t  events,
    input  counterEnables_t enables,
    output counterValues_t  values
);

    logic [NUM_COUNTERS-1:0] eventVec;
    logic [NUM_COUNTERS-1:0] countEn;
    logic [NUM_COUNTERS-1:0] writeEn;
    logic                    mRangeWrite;

    //////////////////////////////////////////////////
    // event to slot mapping
    //////////////////////////////////////////////////
    always_comb begin
        // unwired slots default to no event
        eventVec = '0;
        // cycle counter
        eventVec[0] = 1'b1;
        // slot 1 is time, never counts here
        eventVec[2] = events.instrValid;
        eventVec[3] = events.loadStall;
        eventVec[4] = events.predWrong;
        eventVec[5] = events.instrClass0;
        // slots 6 and 7 only change on writes
    end

    // inhibit bit gates the increment
    assign countEn = eventVec & ~enables.inhibit;

    //////////////////////////////////////////////////
    // machine counter write decode
    //////////////////////////////////////////////////
    assign mRangeWrite = csrReq.write &&
        (csrReq.addr[CSR_ADDR_W-1:INDEX_W] == ADDR_MCOUNTER_BASE[CSR_ADDR_W-1:INDEX_W]);

    always_comb begin
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            // one-hot on the low address bits, time slot excluded
            writeEn[i] = mRangeWrite &&
                         (csrReq.addr[INDEX_W-1:0] == INDEX_W'(i)) &&
                         (i != TIME_INDEX);
        end
    end

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            values <= '0;
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                if (i == TIME_INDEX) begin
                    values[i] <= '0;
                end else if (writeEn[i]) begin
                    // write wins over the increment
                    values[i] <= csrReq.wdata;
                end else if (countEn[i]) begin
                    values[i] <= values[i] + XLEN'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/counterAccessCheck.sv
// counter access check
// decodes the CSR address into a counter slot and decides whether
// the current privilege mode may read it
`default_nettype none

module counterAccessCheck import counterPkg::*; (
    input  csrReq_t         csrReq,
    input  counterEnables_t enables,
    output accessDecision_t decision
);

    logic               inMRange;
    logic               inURange;
    logic               notTime;
    logic [INDEX_W-1:0] idx;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////
    always_comb begin
        idx = csrReq.addr[INDEX_W-1:0];
        // compare everything above the slot bits
        inMRange = csrReq.addr[CSR_ADDR_W-1:INDEX_W] ==
                   ADDR_MCOUNTER_BASE[CSR_ADDR_W-1:INDEX_W];
        inURange = csrReq.addr[CSR_ADDR_W-1:INDEX_W] ==
                   ADDR_UCOUNTER_BASE[CSR_ADDR_W-1:INDEX_W];
        // time is left out in both ranges
        notTime  = idx != INDEX_W'(TIME_INDEX);
    end

    //////////////////////////////////////////////////
    // privilege rules
    //////////////////////////////////////////////////
    always_comb begin
        decision.index     = idx;
        decision.isCounter = (inMRange || inURange) && notTime;
        case (csrReq.priv)
            // machine mode sees every counter
            M: begin
                decision.legal = decision.isCounter;
            end
            // supervisor: user range only, gated by mcounteren
            S: begin
                decision.legal = inURange && notTime && enables.mEnable[idx];
            end
            // user: needs both enable levels
            U: begin
                decision.legal = inURange && notTime &&
                                 enables.mEnable[idx] && enables.sEnable[idx];
            end
            // reserved mode code
            default: begin
                decision.legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/counterReadMux.sv
// counter read mux
// picks the addressed counter value or flags an illegal access
`default_nettype none

module counterReadMux import counterPkg::*; (
    input  counterValues_t   values,
    input  accessDecision_t  decision,
    output logic [XLEN-1:0]  readData,
    output logic             illegal
);

    logic hit;

    // both a counter address and permitted
    assign hit = decision.isCounter && decision.legal;

    always_comb begin
        if (hit) begin
            readData = values[decision.index];
            illegal  = 1'b0;
        end else begin
            // zero data on any refused read
            readData = '0;
            illegal  = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/counterCsrTop.sv
// counter CSR top
// enable registers, counter bank, access check and read mux
// for a 64-bit hart; reads combinational, writes land at the next edge
`default_nettype none

module counterCsrTop import counterPkg::*; (
    input  wire logic       clk,
    input  wire logic       arstN,
    input  csrReq_t         csrReq,
    input  counterEvents_t  events,
    output logic [XLEN-1:0] readData,
    output logic            illegal
);

    counterEnables_t enables;
    counterValues_t  values;
    accessDecision_t decision;

    //////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////
    // enable registers feed both bank and check
    counterCtrlRegs ctrlRegs (
        .clk     (clk),
        .arstN   (arstN),
        .csrReq  (csrReq),
        .enables (enables)
    );

    counterBank bank (
        .clk     (clk),
        .arstN   (arstN),
        .csrReq  (csrReq),
        .events  (events),
        .enables (enables),
        .values  (values)
    );

    //////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////
    // runs alongside the bank, no register in between
    counterAccessCheck accessCheck (
        .csrReq   (csrReq),
        .enables  (enables),
        .decision (decision)
    );

    counterReadMux readMux (
        .values   (values),
        .decision (decision),
        .readData (readData),
        .illegal  (illegal)
    );

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
// testbench clock and reset
// 4 unit clock period, reset low for the first 10 cycles
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        // release between edges, clear of both
        #1 arstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/counterCsrTb.sv
// counter CSR testbench
// table of CSR accesses with random events in between, checked
// against a reference model of the counters and the inhibit register
`default_nettype none

module counterCsrTb import counterPkg::*; ();

    typedef struct {
        string                 name;
        privMode_t             priv;
        logic [CSR_ADDR_W-1:0] addr;
        logic                  write;
        logic [XLEN-1:0]       wdata;
        counterEvents_t        events;
        int                    idle;
        logic                  expIllegal;
    } testEntry_t;

    logic            clk;
    logic            arstN;
    csrReq_t         csrReq;
    counterEvents_t  events;
    logic [XLEN-1:0] readData;
    logic            illegal;

    testEntry_t              stimTable[$];
    logic [XLEN-1:0]         modelCount [NUM_COUNTERS];
    logic [NUM_COUNTERS-1:0] modelInhibit;
    integer                  seed;
    int                      dataErrors;
    int                      illegalErrors;
    int                      otherErrors;

    clockGen clocks (.clk(clk), .arstN(arstN));

    counterCsrTop DUT (
        .clk      (clk),
        .arstN    (arstN),
        .csrReq   (csrReq),
        .events   (events),
        .readData (readData),
        .illegal  (illegal)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic checkData(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            dataErrors++;
        end
    endtask

    task automatic checkIllegal(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected illegal %b, actual %b", name, exp, act);
            illegalErrors++;
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    // state after the coming rising edge
    task automatic modelEdge(csrReq_t req, counterEvents_t ev);
        logic [NUM_COUNTERS-1:0] evSlots;
        // slot 0 every cycle, slot 1 never, 6 and 7 unwired
        evSlots = {2'b00, ev.instrClass0, ev.predWrong, ev.loadStall, ev.instrValid, 2'b01};
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            if (req.write && i != TIME_INDEX &&
                req.addr == ADDR_MCOUNTER_BASE + CSR_ADDR_W'(i)) begin
                modelCount[i] = req.wdata;
            end else if (evSlots[i] && !modelInhibit[i]) begin
                modelCount[i] = modelCount[i] + 1'b1;
            end
        end
        // new inhibit only affects later edges
        if (req.write && req.addr == ADDR_MCOUNTINHIBIT) begin
            modelInhibit = req.wdata[NUM_COUNTERS-1:0];
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic addEntry(string name, privMode_t priv, logic [CSR_ADDR_W-1:0] addr,
                            logic write, logic [XLEN-1:0] wdata, counterEvents_t ev,
                            int idle, logic expIllegal);
        stimTable.push_back('{name, priv, addr, write, wdata, ev, idle, expIllegal});
    endtask

    // called on a falling edge, returns on the next one
    task automatic runEntry(testEntry_t t);
        csrReq_t         idleReq;
        csrReq_t         req;
        logic [31:0]     r;
        logic [XLEN-1:0] expData;
        idleReq = '{addr: '0, write: 1'b0, wdata: '0, priv: M};
        for (int c = 0; c < t.idle; c++) begin
            r = $random(seed);
            csrReq = idleReq;
            events = r[3:0];
            #1;
            modelEdge(idleReq, r[3:0]);
            @(negedge clk);
        end
        req = '{addr: t.addr, write: t.write, wdata: t.wdata, priv: t.priv};
        csrReq = req;
        events = t.events;
        #1;
        // read data is the slot picked by the low address bits
        expData = t.expIllegal ? '0 : modelCount[t.addr[INDEX_W-1:0]];
        checkIllegal(t.name, t.expIllegal, illegal);
        checkData(t.name, expData, readData);
        modelEdge(req, t.events);
        @(negedge clk);
    endtask

    task automatic buildTable();
        addEntry("cycle after reset", M, 12'hB00, 1'b0, 64'h0, 4'hF, 20, 1'b0);
        addEntry("instret count", M, 12'hB02, 1'b0, 64'h0, 4'h0, 4, 1'b0);
        addEntry("stall count", M, 12'hB03, 1'b0, 64'h0, 4'h0, 4, 1'b0);
        addEntry("mispredict count", M, 12'hB04, 1'b0, 64'h0, 4'h0, 4, 1'b0);
        addEntry("class0 count", M, 12'hB05, 1'b0, 64'h0, 4'h0, 4, 1'b0);
        addEntry("slot6 unwired", M, 12'hB06, 1'b0, 64'h0, 4'hF, 2, 1'b0);
        addEntry("write slot3", M, 12'hB03, 1'b1, 64'h1234_5678_9abc_def0, 4'hF, 0, 1'b0);
        addEntry("slot3 after write", M, 12'hB03, 1'b0, 64'h0, 4'h0, 5, 1'b0);
        addEntry("write cycle near wrap", M, 12'hB00, 1'b1, 64'hffff_ffff_ffff_fffc, 4'h0, 0, 1'b0);
        addEntry("cycle wraps", M, 12'hB00, 1'b0, 64'h0, 4'h0, 6, 1'b0);
        addEntry("inhibit slots 0 2", M, 12'h320, 1'b1, 64'h5, 4'hF, 0, 1'b1);
        addEntry("slot2 frozen", M, 12'hB02, 1'b0, 64'h0, 4'hF, 8, 1'b0);
        addEntry("cycle frozen", M, 12'hB00, 1'b0, 64'h0, 4'h0, 3, 1'b0);
        addEntry("inhibit cleared", M, 12'h320, 1'b1, 64'h0, 4'h0, 0, 1'b1);
        addEntry("slot2 resumes", M, 12'hB02, 1'b0, 64'h0, 4'h0, 6, 1'b0);
        addEntry("S user no enable", S, 12'hC02, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("set mcounteren", M, 12'h306, 1'b1, 64'h0d, 4'h0, 0, 1'b1);
        addEntry("set scounteren", M, 12'h106, 1'b1, 64'h17, 4'h0, 0, 1'b1);
        addEntry("S enabled slot3", S, 12'hC03, 1'b0, 64'h0, 4'h0, 1, 1'b0);
        addEntry("S disabled slot4", S, 12'hC04, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("U both enables slot2", U, 12'hC02, 1'b0, 64'h0, 4'h0, 1, 1'b0);
        addEntry("U no sEnable slot3", U, 12'hC03, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("U no mEnable slot4", U, 12'hC04, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("S machine range", S, 12'hB00, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("U machine range", U, 12'hB02, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("M user range", M, 12'hC05, 1'b0, 64'h0, 4'h0, 2, 1'b0);
        addEntry("time machine range", M, 12'hB01, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("time user range", U, 12'hC01, 1'b0, 64'h0, 4'h0, 0, 1'b1);
        addEntry("outside ranges", M, 12'hB08, 1'b0, 64'h0, 4'h0, 0, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        logic resetSeen;
        seed = 32'h5f93_ea6a;
        csrReq = '0;
        csrReq.priv = M;
        events = '0;
        for (int i = 0; i < NUM_COUNTERS; i++) begin
            modelCount[i] = '0;
        end
        modelInhibit = '0;
        dataErrors = 0;
        illegalErrors = 0;
        otherErrors = 0;
        buildTable();
        // wait for reset release, bounded at 50 cycles
        resetSeen = 1'b0;
        for (int i = 0; i < 50 && !resetSeen; i++) begin
            @(negedge clk);
            resetSeen = arstN;
        end
        if (!resetSeen) begin
            $display("reset was never released");
            otherErrors++;
        end else begin
            foreach (stimTable[n]) begin
                runEntry(stimTable[n]);
            end
        end
        $display("errors: data %0d, illegal flag %0d, other %0d",
                 dataErrors, illegalErrors, otherErrors);
        if (dataErrors + illegalErrors + otherErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- counterCsr.f
hdl/counterPkg.sv
hdl/counterCtrlRegs.sv
hdl/counterBank.sv
hdl/counterAccessCheck.sv
hdl/counterReadMux.sv
hdl/counterCsrTop.sv
testbench/clockGen.sv
testbench/counterCsrTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# build and run the counter CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module counterCsrTb \
    -f counterCsr.f -o counterCsrSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/counterCsrSim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0
